// ==== filelist.f ====
verilog/i2cLogPkg.sv
verilog/axiRegPkg.sv
verilog/busConditionDetect.sv
verilog/byteDeserializer.sv
verilog/logCtrl.sv
verilog/logMemory.sv
verilog/axiLiteSlave.sv
verilog/i2cLogTop.sv
verification/logChecker.sv
verification/tbI2cLog.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tbI2cLog -f filelist.f -o simTb &&
./obj_dir/simTb 2>&1 | tee sim.log
grep -q "^Test OK$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== verification/logChecker.sv ====
`timescale 1ns/10ps

module logChecker
(
	input  logic Clk,
	input  logic [axiRegPkg::AddrWidth-1:0] awAddr,
	input  logic awValid,
	input  logic awReady,
	input  logic wReady,
	input  logic [1:0] bResp,
	input  logic bValid,
	input  logic bReady,
	input  logic [axiRegPkg::AddrWidth-1:0] arAddr,
	input  logic arValid,
	input  logic arReady,
	input  logic [31:0] rData,
	input  logic [1:0] rResp,
	input  logic rValid,
	input  logic rReady,
	input  logic [31:0] expData,
	input  logic [1:0] expResp,
	input  logic expCheckData,
	input  logic testEnd,
	input  int testId,
	output int totalChecks,
	output int totalErrors
);

	// Counts for the test that is running and for the whole run
	int testChecks = 0;
	int testErrors = 0;
	int checkCount = 0;
	int errorCount = 0;

	// Address of the read in flight as taken from the AR handshake
	logic [axiRegPkg::AddrWidth-1:0] readAddr = '0;

	// Address of the last accepted write, reported with its response
	logic [axiRegPkg::AddrWidth-1:0] writeAddr = '0;

	// Set when the previous edge saw RVALID without RREADY
	logic stalled = 1'b0;
	logic [31:0] heldData = '0;

	assign totalChecks = checkCount;
	assign totalErrors = errorCount;

	function automatic string testName(input int id);
		case (id)
			1: return "one-byte write";
			2: return "page write with NACK";
			3: return "random read";
			4: return "overflow";
			5: return "clear and disable";
			6: return "host back-pressure";
			default: return "unnamed";
		endcase
	endfunction

	// A mismatch prints the signal, the bus address and both values in hex
	task automatic compareValue(input string name,
		input logic [axiRegPkg::AddrWidth-1:0] addr, input logic [31:0] got,
		input logic [31:0] want);
		testChecks++;
		checkCount++;
		if (got !== want)
		begin
			testErrors++;
			errorCount++;
			$display("Fail %s at 0x%h: got 0x%h, expected 0x%h", name, addr, got, want);
		end
	endtask

	always @(posedge Clk)
	begin
		if (arValid && arReady)
			readAddr <= arAddr;
		if (awValid && awReady)
			writeAddr <= awAddr;
		// AWREADY and WREADY rise together and fall together
		if (awReady || wReady)
			compareValue("wReady", awAddr, 32'(wReady), 32'(awReady));
		// The testbench writes only the control register, which answers OKAY
		if (bValid && bReady)
			compareValue("bResp", writeAddr, 32'(bResp), 32'(axiRegPkg::Okay));
		// While the host stalls, the slave must keep the response steady
		if (stalled)
		begin
			compareValue("rValid", readAddr, 32'(rValid), 32'h1);
			compareValue("rData", readAddr, rData, heldData);
		end
		stalled <= rValid && !rReady;
		heldData <= rData;
		// The R handshake is where the returned word counts
		if (rValid && rReady)
		begin
			if (expCheckData)
				compareValue("rData", readAddr, rData, expData);
			compareValue("rResp", readAddr, 32'(rResp), 32'(expResp));
		end
		if (testEnd)
		begin
			$display("test %0d %s: %0d checks, %0d errors, %s", testId, testName(testId),
				testChecks, testErrors, (testErrors == 0) ? "passed" : "failed");
			testChecks = 0;
			testErrors = 0;
		end
	end

endmodule

// ==== verification/tbI2cLog.sv ====
`timescale 1ns/10ps

module tbI2cLog;

	localparam int LogDepth = 64;

	// Control write issued before a row's bus traffic
	localparam int CtrlNone = 0;
	localparam int CtrlClearEnable = 1;
	localparam int CtrlDisable = 2;

	// In one row of bus traffic ackMask bit n is the level on the ninth clock of frame n
	typedef struct
	{
		int testId;
		int ctrl;
		logic [7:0] devByte;
		int payloadLen;
		logic [15:0] ackMask;
		bit endRestart;
		int hostStall;
		bit probeUnmapped;
	} stepRow;

	logic Clk;
	logic Rst;
	logic scl;
	logic sda;
	logic [axiRegPkg::AddrWidth-1:0] awAddr;
	logic awValid;
	logic awReady;
	logic [31:0] wData;
	logic [3:0] wStrb;
	logic wValid;
	logic wReady;
	logic [1:0] bResp;
	logic bValid;
	logic bReady;
	logic [axiRegPkg::AddrWidth-1:0] arAddr;
	logic arValid;
	logic arReady;
	logic [31:0] rData;
	logic [1:0] rResp;
	logic rValid;
	logic rReady;

	// Expected response that is set before each read is issued
	logic [31:0] expData;
	logic [1:0] expResp;
	logic expCheckData;
	logic testEnd;
	int testId;
	int totalChecks;
	int totalErrors;

	stepRow steps[$];
	logic [15:0] lfsrState;

	// Reference model of the log contents
	logic [i2cLogPkg::RecordWidth-1:0] expRecs [LogDepth];
	int expCount;
	logic expOverflow;
	logic expEnabled;

	int cycleCount = 0;
	int cycleLimit = 0;

	i2cLogTop #(.LogDepth(LogDepth)) i_dut
	(
		.Clk(Clk), .Rst(Rst), .scl(scl), .sda(sda),
		.awAddr(awAddr), .awValid(awValid), .awReady(awReady),
		.wData(wData), .wStrb(wStrb), .wValid(wValid), .wReady(wReady),
		.bResp(bResp), .bValid(bValid), .bReady(bReady),
		.arAddr(arAddr), .arValid(arValid), .arReady(arReady),
		.rData(rData), .rResp(rResp), .rValid(rValid), .rReady(rReady)
	);

	logChecker i_checker
	(
		.Clk(Clk),
		.awAddr(awAddr), .awValid(awValid), .awReady(awReady), .wReady(wReady),
		.bResp(bResp), .bValid(bValid), .bReady(bReady),
		.arAddr(arAddr), .arValid(arValid), .arReady(arReady),
		.rData(rData), .rResp(rResp), .rValid(rValid), .rReady(rReady),
		.expData(expData), .expResp(expResp), .expCheckData(expCheckData),
		.testEnd(testEnd), .testId(testId),
		.totalChecks(totalChecks), .totalErrors(totalErrors)
	);

	initial
	begin
		Clk = 1'b0;
		forever #10 Clk = ~Clk;
	end

	// Galois form of x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] state);
		logic [15:0] next;
		next = state >> 1;
		if (state[0])
			next = next ^ 16'hB400;
		return next;
	endfunction

	// Each payload bit is one LFSR step and the MSB is taken first
	task automatic randomByte(output logic [7:0] value);
		for (int i = 0; i < 8; i++)
		begin
			value = {value[6:0], lfsrState[0]};
			lfsrState = lfsrStep(lfsrState);
		end
	endtask

	task automatic addRow(input int test, input int ctrl, input logic [7:0] dev,
		input int len, input logic [15:0] mask, input bit restart, input int stall,
		input bit probe);
		stepRow row;
		row.testId = test;
		row.ctrl = ctrl;
		row.devByte = dev;
		row.payloadLen = len;
		row.ackMask = mask;
		row.endRestart = restart;
		row.hostStall = stall;
		row.probeUnmapped = probe;
		steps.push_back(row);
	endtask

	task automatic buildSteps();
		addRow(1, CtrlClearEnable, 8'hA0, 1, 16'h0000, 1'b0, 0, 1'b0);
		// The last data byte of the page is not acknowledged
		addRow(2, CtrlClearEnable, 8'hA0, 8, 16'h0100, 1'b0, 0, 1'b0);
		// Word address write, then a repeated START into a two byte read
		addRow(3, CtrlClearEnable, 8'hA0, 1, 16'h0000, 1'b1, 0, 1'b0);
		addRow(3, CtrlNone, 8'hA1, 2, 16'h0004, 1'b0, 0, 1'b0);
		// Eighty frames against a log of sixty four
		addRow(4, CtrlClearEnable, 8'hA0, 15, 16'h0000, 1'b0, 0, 1'b0);
		addRow(4, CtrlNone, 8'hA2, 15, 16'h0000, 1'b0, 0, 1'b0);
		addRow(4, CtrlNone, 8'hA4, 15, 16'h0000, 1'b0, 0, 1'b0);
		addRow(4, CtrlNone, 8'hA6, 15, 16'h0000, 1'b0, 0, 1'b0);
		addRow(4, CtrlNone, 8'hA8, 15, 16'h0000, 1'b0, 0, 1'b0);
		addRow(5, CtrlClearEnable, 8'hA0, 1, 16'h0000, 1'b0, 0, 1'b0);
		addRow(5, CtrlDisable, 8'hA0, 3, 16'h0000, 1'b0, 0, 1'b0);
		addRow(6, CtrlClearEnable, 8'hA0, 2, 16'h0000, 1'b0, 5, 1'b1);
	endtask

	// Start, nine bits per frame, stop, a control write and a full read-back
	function automatic int rowCycles(input stepRow row);
		return 16 + (row.payloadLen + 1) * 9 * 16 + 12 + 40 +
			(LogDepth + 3) * (16 + row.hostStall);
	endfunction

	task automatic waitCycles(input int n);
		repeat (n) @(negedge Clk);
	endtask

	// Also serves as repeated START when SCL is low
	task automatic sendStart();
		sda = 1'b1;
		waitCycles(4);
		scl = 1'b1;
		waitCycles(4);
		sda = 1'b0;
		waitCycles(4);
		scl = 1'b0;
		waitCycles(4);
	endtask

	task automatic sendStop();
		sda = 1'b0;
		waitCycles(4);
		scl = 1'b1;
		waitCycles(4);
		sda = 1'b1;
		waitCycles(4);
	endtask

	// SDA changes only while SCL is low and one bit lasts sixteen Clk cycles
	task automatic sendBit(input logic level);
		sda = level;
		waitCycles(4);
		scl = 1'b1;
		waitCycles(8);
		scl = 1'b0;
		waitCycles(4);
	endtask

	task automatic sendFrame(input logic [7:0] value, input logic nack);
		for (int i = 7; i >= 0; i--)
			sendBit(value[i]);
		sendBit(nack);
	endtask

	// Start flag goes in bit 9 and the acknowledge level in bit 8 above the data
	task automatic logRecord(input logic [7:0] value, input logic nack, input logic first);
		logic [i2cLogPkg::RecordWidth-1:0] rec;
		rec = {first, nack, value};
		if (expEnabled)
		begin
			if (expCount < LogDepth)
			begin
				expRecs[expCount] = rec;
				expCount++;
			end
			else
				expOverflow = 1'b1;
		end
	endtask

	task automatic writeControl(input logic [31:0] value);
		@(negedge Clk);
		awAddr = axiRegPkg::ControlOffset;
		wData = value;
		wStrb = 4'hF;
		awValid = 1'b1;
		wValid = 1'b1;
		@(negedge Clk);
		while (!awReady)
			@(negedge Clk);
		@(negedge Clk);
		awValid = 1'b0;
		wValid = 1'b0;
		while (!bValid)
			@(negedge Clk);
		@(negedge Clk);
	endtask

	// RREADY stays low for stall cycles after RVALID rises
	task automatic readCheck(input logic [axiRegPkg::AddrWidth-1:0] addr,
		input logic [31:0] data, input logic [1:0] resp, input logic checkData,
		input int stall);
		@(negedge Clk);
		expData = data;
		expResp = resp;
		expCheckData = checkData;
		arAddr = addr;
		arValid = 1'b1;
		@(negedge Clk);
		while (!arReady)
			@(negedge Clk);
		@(negedge Clk);
		arValid = 1'b0;
		while (!rValid)
			@(negedge Clk);
		waitCycles(stall);
		rReady = 1'b1;
		@(negedge Clk);
		rReady = 1'b0;
	endtask

	task automatic runRow(input stepRow row);
		logic [31:0] ctrlWord;
		logic [7:0] dataByte;
		ctrlWord = '0;
		if (row.ctrl == CtrlClearEnable)
		begin
			ctrlWord[axiRegPkg::EnableBit] = 1'b1;
			ctrlWord[axiRegPkg::ClearBit] = 1'b1;
			writeControl(ctrlWord);
			expCount = 0;
			expOverflow = 1'b0;
			expEnabled = 1'b1;
		end
		else if (row.ctrl == CtrlDisable)
		begin
			writeControl(ctrlWord);
			expEnabled = 1'b0;
		end
		sendStart();
		for (int f = 0; f <= row.payloadLen; f++)
		begin
			if (f == 0)
				dataByte = row.devByte;
			else
				randomByte(dataByte);
			sendFrame(dataByte, row.ackMask[f]);
			logRecord(dataByte, row.ackMask[f], f == 0);
		end
		if (!row.endRestart)
			sendStop();
	endtask

	// Read status first and then every record the model holds
	task automatic checkTest(input stepRow row);
		logic [31:0] statusExp;
		statusExp = 32'(expCount);
		statusExp[axiRegPkg::OverflowBit] = expOverflow;
		readCheck(axiRegPkg::StatusOffset, statusExp, axiRegPkg::Okay, 1'b1, row.hostStall);
		for (int i = 0; i < expCount; i++)
			readCheck(axiRegPkg::LogWindowOffset + 12'(4 * i), 32'(expRecs[i]),
				axiRegPkg::Okay, 1'b1, row.hostStall);
		// Hole between control and the window
		if (row.probeUnmapped)
			readCheck(12'h008, 32'h0, axiRegPkg::SlvErr, 1'b0, 0);
		@(negedge Clk);
		testId = row.testId;
		testEnd = 1'b1;
		@(negedge Clk);
		testEnd = 1'b0;
	endtask

	always @(posedge Clk)
	begin
		cycleCount <= cycleCount + 1;
		if ((cycleLimit > 0) && (cycleCount > cycleLimit))
		begin
			$display("Run hung: %0d cycles passed without the tests finishing", cycleLimit);
			$display("Test FAILED");
			$finish;
		end
	end

	initial
	begin
		int sumCycles;
		Rst = 1'b1;
		scl = 1'b1;
		sda = 1'b1;
		awAddr = '0;
		awValid = 1'b0;
		wData = '0;
		wStrb = '0;
		wValid = 1'b0;
		bReady = 1'b1;
		arAddr = '0;
		arValid = 1'b0;
		rReady = 1'b0;
		expData = '0;
		expResp = '0;
		expCheckData = 1'b0;
		testEnd = 1'b0;
		testId = 0;
		lfsrState = 16'd47209;
		expCount = 0;
		expOverflow = 1'b0;
		expEnabled = 1'b0;
		buildSteps();
		sumCycles = 0;
		foreach (steps[r])
			sumCycles += rowCycles(steps[r]);
		cycleLimit = 2 * sumCycles;
		waitCycles(2);
		Rst = 1'b0;
		for (int r = 0; r < steps.size(); r++)
		begin
			runRow(steps[r]);
			// The last row of a test triggers the read-back
			if ((r == steps.size() - 1) || (steps[r + 1].testId != steps[r].testId))
				checkTest(steps[r]);
		end
		waitCycles(4);
		$display("Totals: %0d checks, %0d errors", totalChecks, totalErrors);
		if (totalErrors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== verilog/axiLiteSlave.sv ====
`timescale 1ns/10ps

module axiLiteSlave
#(
	parameter int LogDepth = 64
)
(
	input  logic Clk,
	input  logic Rst,
	input  logic [axiRegPkg::AddrWidth-1:0] awAddr,
	input  logic awValid,
	output logic awReady,
	input  logic [31:0] wData,
	input  logic [3:0] wStrb,
	input  logic wValid,
	output logic wReady,
	output logic [1:0] bResp,
	output logic bValid,
	input  logic bReady,
	input  logic [axiRegPkg::AddrWidth-1:0] arAddr,
	input  logic arValid,
	output logic arReady,
	output logic [31:0] rData,
	output logic [1:0] rResp,
	output logic rValid,
	input  logic rReady,
	output logic [$clog2(LogDepth)-1:0] memReadAddr,
	input  logic [i2cLogPkg::RecordWidth-1:0] memReadData,
	input  logic [$clog2(LogDepth):0] recordCount,
	input  logic overflow,
	output logic logEnable,
	output logic logClear
);

	localparam int IndexWidth = $clog2(LogDepth);
	localparam int CountWidth = IndexWidth + 1;

	// Address and data channels are accepted together by one ready flop
	logic writeReady;
	logic writeFire;
	logic readFire;
	logic readPending;
	// Stage 0 waits for the memory, stage 1 loads rData
	logic [1:0] readStage;
	logic [axiRegPkg::AddrWidth-1:0] readAddr;
	logic [axiRegPkg::AddrWidth-1:0] arWindowOffset;
	logic [axiRegPkg::AddrWidth-1:0] readWindowOffset;
	logic [31:0] statusWord;
	logic [31:0] controlWord;
	logic [31:0] readWord;
	logic [1:0] readResp;
	logic [1:0] writeResp;

	assign awReady = writeReady;
	assign wReady = writeReady;
	assign writeFire = awValid & wValid & writeReady;
	assign readFire = arValid & arReady;

	assign arWindowOffset = arAddr - axiRegPkg::LogWindowOffset;
	assign readWindowOffset = readAddr - axiRegPkg::LogWindowOffset;

	always_comb
	begin
		statusWord = '0;
		statusWord[CountWidth-1:0] = recordCount;
		statusWord[axiRegPkg::OverflowBit] = overflow;
		controlWord = '0;
		controlWord[axiRegPkg::EnableBit] = logEnable;
	end

	// Decode of the latched read address, the window covers LogDepth words
	always_comb
	begin
		readWord = '0;
		readResp = axiRegPkg::Okay;
		if (readAddr == axiRegPkg::StatusOffset)
			readWord = statusWord;
		else if (readAddr == axiRegPkg::ControlOffset)
			readWord = controlWord;
		else if ((readAddr >= axiRegPkg::LogWindowOffset) &&
			(readWindowOffset < axiRegPkg::AddrWidth'(4 * LogDepth)))
			// Words above recordCount still return whatever the memory holds
			readWord = 32'(memReadData);
		else
			readResp = axiRegPkg::SlvErr;
	end

	// Status takes writes without effect, anything else outside control errors
	assign writeResp = ((awAddr == axiRegPkg::StatusOffset) ||
		(awAddr == axiRegPkg::ControlOffset)) ? axiRegPkg::Okay : axiRegPkg::SlvErr;

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			writeReady <= 1'b0;
			bValid <= 1'b0;
			logEnable <= 1'b0;
			logClear <= 1'b0;
			arReady <= 1'b0;
			rValid <= 1'b0;
			readPending <= 1'b0;
			readStage <= '0;
		end
		else
		begin
			// Ready pulses for one cycle and waits until the response is taken
			writeReady <= awValid & wValid & ~writeReady & ~bValid;
			logClear <= 1'b0;
			if (writeFire)
			begin
				bValid <= 1'b1;
				if ((awAddr == axiRegPkg::ControlOffset) && wStrb[0])
				begin
					logEnable <= wData[axiRegPkg::EnableBit];
					logClear <= wData[axiRegPkg::ClearBit];
				end
			end
			else if (bValid & bReady)
			begin
				bValid <= 1'b0;
			end
			// Only one read is in flight, the next waits for the R handshake
			arReady <= arValid & ~readPending & ~arReady;
			readStage <= {readStage[0], readFire};
			if (readFire)
				readPending <= 1'b1;
			if (readStage[1])
			begin
				rValid <= 1'b1;
			end
			else if (rValid & rReady)
			begin
				rValid <= 1'b0;
				readPending <= 1'b0;
			end
		end
	end

	// Payload registers, rData holds steady while the host stalls RREADY
	always_ff @(posedge Clk)
	begin
		if (writeFire)
			bResp <= writeResp;
		if (readFire)
		begin
			readAddr <= arAddr;
			memReadAddr <= arWindowOffset[2 +: IndexWidth];
		end
		if (readStage[1])
		begin
			rData <= readWord;
			rResp <= readResp;
		end
	end

endmodule

// ==== verilog/axiRegPkg.sv ====
package axiRegPkg;

	// Byte address width of the host register space
	localparam int AddrWidth = 12;

	// Record count in the low bits, overflow in the top bit
	localparam logic [AddrWidth-1:0] StatusOffset = 12'h000;
	localparam int OverflowBit = 31;

	// Enable level and self-clearing log clear
	localparam logic [AddrWidth-1:0] ControlOffset = 12'h004;
	localparam int EnableBit = 0;
	localparam int ClearBit = 1;

	// Record n lives at this base plus four times n
	localparam logic [AddrWidth-1:0] LogWindowOffset = 12'h100;

	// AXI response codes that this slave returns
	typedef enum logic [1:0]
	{
		Okay = 2'b00,
		SlvErr = 2'b10
	} axiResp;

endpackage

// ==== verilog/busConditionDetect.sv ====
`timescale 1ns/10ps

module busConditionDetect
(
	input  logic Clk,
	input  logic Rst,
	input  logic scl,
	input  logic sda,
	output logic sdaSync,
	output logic sclRise,
	output logic startSeen,
	output logic stopSeen
);

	// Two flop stages per pin bring the bus lines into the Clk domain
	logic [1:0] sclMeta;
	logic [1:0] sdaMeta;

	// Synchronized levels one cycle older, the reference for edge detection
	logic sclPrev;
	logic sdaPrev;

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			// An idle bus is high on both lines, so no false edge follows reset
			sclMeta <= 2'b11;
			sdaMeta <= 2'b11;
			sclPrev <= 1'b1;
			sdaPrev <= 1'b1;
			sclRise <= 1'b0;
			startSeen <= 1'b0;
			stopSeen <= 1'b0;
		end
		else
		begin
			sclMeta <= {sclMeta[0], scl};
			sdaMeta <= {sdaMeta[0], sda};
			sclPrev <= sclMeta[1];
			sdaPrev <= sdaMeta[1];
			// Rising SCL is the sample point for every data and acknowledge bit
			sclRise <= sclMeta[1] & ~sclPrev;
			// SDA falling while SCL stays high is a START or repeated START
			startSeen <= sclMeta[1] & sclPrev & sdaPrev & ~sdaMeta[1];
			// SDA rising while SCL stays high is a STOP
			stopSeen <= sclMeta[1] & sclPrev & ~sdaPrev & sdaMeta[1];
		end
	end

	// Same age as the registered pulses, so the data bit lines up with sclRise
	assign sdaSync = sdaPrev;

endmodule

// ==== verilog/byteDeserializer.sv ====
`timescale 1ns/10ps

module byteDeserializer
(
	input  logic Clk,
	input  logic Rst,
	input  logic sclRise,
	input  logic sdaSync,
	input  logic frameRestart,
	input  logic captureEnable,
	output logic [i2cLogPkg::FrameBits-1:0] frame,
	output logic frameDone
);

	localparam int CountWidth = $clog2(i2cLogPkg::FrameBits + 1);

	// Bits taken so far in the current frame
	logic [CountWidth-1:0] bitCount;

	// A bit is taken only on an SCL rise while the controller wants traffic
	logic takeBit;

	assign takeBit = sclRise & captureEnable;

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			bitCount <= '0;
			frameDone <= 1'b0;
		end
		else
		begin
			frameDone <= 1'b0;
			if (frameRestart)
			begin
				// A START realigns the count to the first bit of a new frame
				bitCount <= '0;
			end
			else if (takeBit)
			begin
				if (bitCount == CountWidth'(i2cLogPkg::FrameBits - 1))
				begin
					// Ninth bit is the acknowledge, the frame is complete
					bitCount <= '0;
					frameDone <= 1'b1;
				end
				else
				begin
					bitCount <= bitCount + 1'b1;
				end
			end
		end
	end

	// Bits arrive MSB first, the acknowledge ends up in bit 0
	always_ff @(posedge Clk)
	begin
		if (takeBit)
		begin
			frame <= {frame[i2cLogPkg::FrameBits-2:0], sdaSync};
		end
	end

endmodule

// ==== verilog/i2cLogPkg.sv ====
package i2cLogPkg;

	// One log record holds data, acknowledge level and start flag
	localparam int RecordWidth = 10;

	// Data byte sits in the low bits of a record
	localparam int DataWidth = 8;

	// Acknowledge level as sampled on the ninth clock, zero means acknowledged
	localparam int AckBit = 8;

	// Set on the first byte after a START or repeated START
	localparam int StartFlagBit = 9;

	// Eight data bits and the acknowledge bit make one frame on the bus
	localparam int FrameBits = 9;

	// Capture sequencing of the logger
	typedef enum logic [1:0]
	{
		Disabled,
		WaitStart,
		Receive,
		Full
	} logState;

endpackage

// ==== verilog/i2cLogTop.sv ====
`timescale 1ns/10ps

module i2cLogTop
#(
	parameter int LogDepth = 64
)
(
	input  logic Clk,
	input  logic Rst,
	input  logic scl,
	input  logic sda,
	input  logic [axiRegPkg::AddrWidth-1:0] awAddr,
	input  logic awValid,
	output logic awReady,
	input  logic [31:0] wData,
	input  logic [3:0] wStrb,
	input  logic wValid,
	output logic wReady,
	output logic [1:0] bResp,
	output logic bValid,
	input  logic bReady,
	input  logic [axiRegPkg::AddrWidth-1:0] arAddr,
	input  logic arValid,
	output logic arReady,
	output logic [31:0] rData,
	output logic [1:0] rResp,
	output logic rValid,
	input  logic rReady
);

	// Bus conditions in the Clk domain
	logic sdaSync;
	logic sclRise;
	logic startSeen;
	logic stopSeen;

	// Frame handoff between the shifter and the controller
	logic frameRestart;
	logic captureEnable;
	logic [i2cLogPkg::FrameBits-1:0] frame;
	logic frameDone;

	// Log memory ports
	logic memWrite;
	logic [$clog2(LogDepth)-1:0] memWriteAddr;
	logic [i2cLogPkg::RecordWidth-1:0] memWriteData;
	logic [$clog2(LogDepth)-1:0] memReadAddr;
	logic [i2cLogPkg::RecordWidth-1:0] memReadData;

	// Host control and status
	logic [$clog2(LogDepth):0] recordCount;
	logic overflow;
	logic logEnable;
	logic logClear;

	busConditionDetect i_busConditionDetect
	(
		.Clk(Clk), .Rst(Rst), .scl(scl), .sda(sda),
		.sdaSync(sdaSync), .sclRise(sclRise),
		.startSeen(startSeen), .stopSeen(stopSeen)
	);

	byteDeserializer i_byteDeserializer
	(
		.Clk(Clk), .Rst(Rst), .sclRise(sclRise), .sdaSync(sdaSync),
		.frameRestart(frameRestart), .captureEnable(captureEnable),
		.frame(frame), .frameDone(frameDone)
	);

	logCtrl #(.LogDepth(LogDepth)) i_logCtrl
	(
		.Clk(Clk), .Rst(Rst), .startSeen(startSeen), .stopSeen(stopSeen),
		.frameDone(frameDone), .frame(frame),
		.logEnable(logEnable), .logClear(logClear),
		.frameRestart(frameRestart), .captureEnable(captureEnable),
		.memWrite(memWrite), .memWriteAddr(memWriteAddr), .memWriteData(memWriteData),
		.recordCount(recordCount), .overflow(overflow)
	);

	logMemory #(.LogDepth(LogDepth)) i_logMemory
	(
		.Clk(Clk), .memWrite(memWrite), .memWriteAddr(memWriteAddr),
		.memWriteData(memWriteData), .memReadAddr(memReadAddr),
		.memReadData(memReadData)
	);

	axiLiteSlave #(.LogDepth(LogDepth)) i_axiLiteSlave
	(
		.Clk(Clk), .Rst(Rst),
		.awAddr(awAddr), .awValid(awValid), .awReady(awReady),
		.wData(wData), .wStrb(wStrb), .wValid(wValid), .wReady(wReady),
		.bResp(bResp), .bValid(bValid), .bReady(bReady),
		.arAddr(arAddr), .arValid(arValid), .arReady(arReady),
		.rData(rData), .rResp(rResp), .rValid(rValid), .rReady(rReady),
		.memReadAddr(memReadAddr), .memReadData(memReadData),
		.recordCount(recordCount), .overflow(overflow),
		.logEnable(logEnable), .logClear(logClear)
	);

endmodule

// ==== verilog/logCtrl.sv ====
`timescale 1ns/10ps

module logCtrl
#(
	parameter int LogDepth = 64
)
(
	input  logic Clk,
	input  logic Rst,
	input  logic startSeen,
	input  logic stopSeen,
	input  logic frameDone,
	input  logic [i2cLogPkg::FrameBits-1:0] frame,
	input  logic logEnable,
	input  logic logClear,
	output logic frameRestart,
	output logic captureEnable,
	output logic memWrite,
	output logic [$clog2(LogDepth)-1:0] memWriteAddr,
	output logic [i2cLogPkg::RecordWidth-1:0] memWriteData,
	output logic [$clog2(LogDepth):0] recordCount,
	output logic overflow
);

	localparam int CountWidth = $clog2(LogDepth) + 1;

	i2cLogPkg::logState state;

	// Marks that the next completed frame directly follows a START
	logic firstFrame;

	// Record assembled from the frame that has just completed
	logic [i2cLogPkg::RecordWidth-1:0] record;

	always_comb
	begin
		record = '0;
		record[i2cLogPkg::DataWidth-1:0] = frame[i2cLogPkg::FrameBits-1:1];
		record[i2cLogPkg::AckBit] = frame[0];
		record[i2cLogPkg::StartFlagBit] = firstFrame;
	end

	// Frames keep counting in Full so that further traffic can flag overflow
	assign captureEnable = (state == i2cLogPkg::Receive) || (state == i2cLogPkg::Full);

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			state <= i2cLogPkg::Disabled;
			recordCount <= '0;
			overflow <= 1'b0;
			memWrite <= 1'b0;
			frameRestart <= 1'b0;
			firstFrame <= 1'b0;
		end
		else
		begin
			memWrite <= 1'b0;
			frameRestart <= startSeen;
			if (startSeen)
			begin
				firstFrame <= 1'b1;
			end
			if (logClear)
			begin
				// Clear beats a record write landing on the same edge
				recordCount <= '0;
				overflow <= 1'b0;
				state <= logEnable ? i2cLogPkg::WaitStart : i2cLogPkg::Disabled;
			end
			else if (!logEnable)
			begin
				state <= i2cLogPkg::Disabled;
			end
			else
			begin
				case (state)
					i2cLogPkg::Disabled:
					begin
						// Re-enabling a full log must not write past its end
						if (recordCount == CountWidth'(LogDepth))
							state <= i2cLogPkg::Full;
						else
							state <= i2cLogPkg::WaitStart;
					end
					i2cLogPkg::WaitStart:
					begin
						if (startSeen)
							state <= i2cLogPkg::Receive;
					end
					i2cLogPkg::Receive:
					begin
						if (stopSeen)
						begin
							state <= i2cLogPkg::WaitStart;
						end
						else if (frameDone)
						begin
							memWrite <= 1'b1;
							recordCount <= recordCount + 1'b1;
							firstFrame <= 1'b0;
							if (recordCount == CountWidth'(LogDepth - 1))
								state <= i2cLogPkg::Full;
						end
					end
					i2cLogPkg::Full:
					begin
						// Earliest traffic is kept, later frames only raise the flag
						if (frameDone)
							overflow <= 1'b1;
					end
					default:
					begin
						state <= i2cLogPkg::Disabled;
					end
				endcase
			end
		end
	end

	// Address and data are sampled with every frame, memWrite decides the store
	always_ff @(posedge Clk)
	begin
		if (frameDone)
		begin
			memWriteAddr <= recordCount[CountWidth-2:0];
			memWriteData <= record;
		end
	end

endmodule

// ==== verilog/logMemory.sv ====
`timescale 1ns/10ps

module logMemory
#(
	parameter int LogDepth = 64
)
(
	input  logic Clk,
	input  logic memWrite,
	input  logic [$clog2(LogDepth)-1:0] memWriteAddr,
	input  logic [i2cLogPkg::RecordWidth-1:0] memWriteData,
	input  logic [$clog2(LogDepth)-1:0] memReadAddr,
	output logic [i2cLogPkg::RecordWidth-1:0] memReadData
);

	// Record array, maps onto one block RAM with a registered output
	logic [i2cLogPkg::RecordWidth-1:0] records [LogDepth];

	// Records are written in order by the controller
	always_ff @(posedge Clk)
	begin
		if (memWrite)
		begin
			records[memWriteAddr] <= memWriteData;
		end
	end

	// The host sees the word one cycle after presenting the address
	always_ff @(posedge Clk)
	begin
		memReadData <= records[memReadAddr];
	end

endmodule
